//--- Bender.yml
package:
  name: wb_subsystem

sources:
  - source/wb_pkg.sv
  - source/id_tracker.sv
  - source/alu_unit.sv
  - source/mul_unit.sv
  - source/write_back.sv
  - source/reg_file.sv
  - source/wb_subsystem.sv
  - target: simulation
    files:
      - testbench/tb_wb_subsystem.sv

//--- list.f
source/wb_pkg.sv
source/id_tracker.sv
source/alu_unit.sv
source/mul_unit.sv
source/write_back.sv
source/reg_file.sv
source/wb_subsystem.sv
testbench/tb_wb_subsystem.sv

//--- source/alu_unit.sv
// Single-cycle ALU for add, subtract and xor
// Result reported one cycle after the issue edge
`timescale 1ns/10ps

module alu_unit (
    input  logic                clk,
    input  logic                rst,
    input  wb_pkg::unit_issue_t unit_issue,
    output wb_pkg::unit_wb_t    wb
);
    import wb_pkg::*;

    logic            accept;
    logic [XLEN-1:0] result;

    // Everything except multiply belongs here
    assign accept = unit_issue.valid && (unit_issue.op != op_mul);

    always_comb begin
        case (unit_issue.op)
            op_add:  result = unit_issue.a + unit_issue.b;
            op_sub:  result = unit_issue.a - unit_issue.b;
            op_xor:  result = unit_issue.a ^ unit_issue.b;
            default: result = '0;
        endcase
    end

    ///////////////////////////////
    // Result register
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.done <= 1'b0;
        end else begin
            wb.done <= accept;
        end
        // Payload follows the done pulse
        wb.id <= unit_issue.id;
        wb.rd <= result;
    end

endmodule

//--- source/id_tracker.sv
// Circular instruction ID allocator
// MAX_INFLIGHT must not exceed 2**ID_W, IDs wrap at MAX_INFLIGHT
`timescale 1ns/10ps

module id_tracker #(
    parameter int MAX_INFLIGHT = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        issued,
    input  logic        retired,
    output wb_pkg::id_t next_id,
    output wb_pkg::id_t oldest_id,
    output logic        id_available,
    output logic        empty
);
    import wb_pkg::*;

    localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);

    // Head allocates, tail follows the oldest in flight
    id_t head;
    id_t tail;
    logic [CNT_W-1:0] inflight_count;

    ///////////////////////////////
    // Pointers
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (issued) begin
                // Wrap at MAX_INFLIGHT rather than at the ID width
                head <= (head == id_t'(MAX_INFLIGHT - 1)) ? '0 : head + 1'b1;
            end
            if (retired) begin
                tail <= (tail == id_t'(MAX_INFLIGHT - 1)) ? '0 : tail + 1'b1;
            end
        end
    end

    // In-flight count, issue and retire can coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            case ({issued, retired})
                2'b10:   inflight_count <= inflight_count + 1'b1;
                2'b01:   inflight_count <= inflight_count - 1'b1;
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    assign next_id      = head;
    assign oldest_id    = tail;
    assign id_available = (inflight_count != CNT_W'(MAX_INFLIGHT));
    assign empty        = (inflight_count == '0);

endmodule

//--- source/mul_unit.sv
// Three-stage pipelined multiplier, low 32 bits of the product only
// Accepts one multiply per cycle, result three cycles after issue
`timescale 1ns/10ps

module mul_unit (
    input  logic                clk,
    input  logic                rst,
    input  wb_pkg::unit_issue_t unit_issue,
    output wb_pkg::unit_wb_t    wb
);
    import wb_pkg::*;

    logic            accept;

    // Stage 1 operands
    logic            s1_valid;
    id_t             s1_id;
    logic [XLEN-1:0] s1_a;
    logic [XLEN-1:0] s1_b;

    // Stage 2 product
    logic            s2_valid;
    id_t             s2_id;
    logic [XLEN-1:0] s2_prod;

    assign accept = unit_issue.valid && (unit_issue.op == op_mul);

    ///////////////////////////////
    // Valid chain
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            wb.done  <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
            wb.done  <= s2_valid;
        end
    end

    ///////////////////////////////
    // Data and ID pipeline
    ///////////////////////////////
    always_ff @(posedge clk) begin
        // Capture operands
        s1_id <= unit_issue.id;
        s1_a  <= unit_issue.a;
        s1_b  <= unit_issue.b;
        // Multiply, 32-bit context keeps only the low half
        s2_id   <= s1_id;
        s2_prod <= s1_a * s1_b;
        // Output stage
        wb.id <= s2_id;
        wb.rd <= s2_prod;
    end

endmodule

//--- source/reg_file.sv
// 32 x 32-bit register file with register 0 held at zero
// Debug read port is combinational
`timescale 1ns/10ps

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  wb_pkg::retire_t   retire,
    input  wb_pkg::reg_addr_t read_addr,
    output logic [31:0]       read_data
);
    import wb_pkg::*;

    logic [XLEN-1:0] regs [32];

    ///////////////////////////////
    // Write port
    ///////////////////////////////
    // Register 0 is skipped on write and keeps its reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (retire.valid && (retire.rd_addr != '0)) begin
            regs[retire.rd_addr] <= retire.rd_data;
        end
    end

    // Combinational debug read
    assign read_data = regs[read_addr];

endmodule

//--- source/wb_pkg.sv
// Shared types for the write-back subsystem
// ID width of 3 bits limits MAX_INFLIGHT to at most 8
package wb_pkg;

    ///////////////////////////////
    // Widths and counts
    ///////////////////////////////
    localparam int XLEN = 32;
    localparam int NUM_WB_UNITS = 2;
    localparam int ID_W = 3;

    typedef logic [ID_W-1:0] id_t;
    typedef logic [4:0] reg_addr_t;

    // Unit selection follows directly from the opcode
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_mul = 2'd3
    } opcode_t;

    ///////////////////////////////
    // Packets
    ///////////////////////////////

    // Incoming instruction at the issue port
    typedef struct packed {
        opcode_t          op;
        reg_addr_t        rd_addr;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
    } issue_packet_t;

    // Broadcast to all execution units
    typedef struct packed {
        logic             valid;
        id_t              id;
        opcode_t          op;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
    } unit_issue_t;

    // Result report from one unit, done is a one-cycle pulse
    typedef struct packed {
        logic             done;
        id_t              id;
        logic [XLEN-1:0]  rd;
    } unit_wb_t;

    // Retired instruction, also the register file write request
    typedef struct packed {
        logic             valid;
        id_t              id;
        reg_addr_t        rd_addr;
        logic [XLEN-1:0]  rd_data;
    } retire_t;

endpackage

//--- source/wb_subsystem.sv
// Top level of the write-back subsystem
// Issue uses valid/ready, retire is a one-cycle strobe
`timescale 1ns/10ps

module wb_subsystem #(
    parameter int MAX_INFLIGHT = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  wb_pkg::issue_packet_t issue,
    input  wb_pkg::reg_addr_t     read_addr,
    output logic                  issue_ready,
    output wb_pkg::retire_t       retire,
    output logic [31:0]           read_data
);
    import wb_pkg::*;

    unit_issue_t unit_issue;
    // Unit 0 is the ALU, unit 1 the multiplier
    unit_wb_t    unit_wb [NUM_WB_UNITS-1:0];

    write_back #(
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) write_back0 (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .unit_wb     (unit_wb),
        .issue_ready (issue_ready),
        .unit_issue  (unit_issue),
        .retire      (retire)
    );

    alu_unit alu_unit0 (
        .clk        (clk),
        .rst        (rst),
        .unit_issue (unit_issue),
        .wb         (unit_wb[0])
    );

    mul_unit mul_unit0 (
        .clk        (clk),
        .rst        (rst),
        .unit_issue (unit_issue),
        .wb         (unit_wb[1])
    );

    reg_file reg_file0 (
        .clk       (clk),
        .rst       (rst),
        .retire    (retire),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

//--- source/write_back.sv
// Result table by ID with in-order retirement
// Results may complete out of order, one retirement per cycle at most
// No back-pressure on the retire port
`timescale 1ns/10ps

module write_back #(
    parameter int MAX_INFLIGHT = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  wb_pkg::issue_packet_t issue,
    input  wb_pkg::unit_wb_t      unit_wb [wb_pkg::NUM_WB_UNITS-1:0],
    output logic                  issue_ready,
    output wb_pkg::unit_issue_t   unit_issue,
    output wb_pkg::retire_t       retire
);
    import wb_pkg::*;

    logic issue_fire;
    id_t  issue_id;
    id_t  oldest_id;
    logic id_available;
    logic tracker_empty;
    logic retired;

    // Destination register per in-flight ID
    reg_addr_t packet_table [MAX_INFLIGHT-1:0];
    // Unit results per in-flight ID
    logic [XLEN-1:0] result_table [MAX_INFLIGHT-1:0];

    logic [MAX_INFLIGHT-1:0] id_done_new;
    logic [MAX_INFLIGHT-1:0] id_retire;
    logic [MAX_INFLIGHT-1:0] id_done_r;

    ///////////////////////////////
    // Issue side
    ///////////////////////////////
    assign issue_ready = id_available;
    assign issue_fire  = issue_valid && id_available;

    // Same broadcast to every unit, each one picks its opcodes
    assign unit_issue.valid = issue_fire;
    assign unit_issue.id    = issue_id;
    assign unit_issue.op    = issue.op;
    assign unit_issue.a     = issue.a;
    assign unit_issue.b     = issue.b;

    id_tracker #(
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) id_tracker0 (
        .clk          (clk),
        .rst          (rst),
        .issued       (issue_fire),
        .retired      (retired),
        .next_id      (issue_id),
        .oldest_id    (oldest_id),
        .id_available (id_available),
        .empty        (tracker_empty)
    );

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            packet_table[issue_id] <= issue.rd_addr;
        end
    end

    ///////////////////////////////
    // Result capture
    ///////////////////////////////

    // One-hot of IDs reported this cycle by any unit
    always_comb begin
        id_done_new = '0;
        for (int u = 0; u < NUM_WB_UNITS; u++) begin
            if (unit_wb[u].done) begin
                id_done_new[unit_wb[u].id] = 1'b1;
            end
        end
    end

    // IDs are unique in flight, so units never collide on a slot
    always_ff @(posedge clk) begin
        for (int u = 0; u < NUM_WB_UNITS; u++) begin
            if (unit_wb[u].done) begin
                result_table[unit_wb[u].id] <= unit_wb[u].rd;
            end
        end
    end

    ///////////////////////////////
    // Done flags and retirement
    ///////////////////////////////
    assign retired = id_done_r[oldest_id] && !tracker_empty;

    always_comb begin
        id_retire = '0;
        id_retire[oldest_id] = retired;
    end

    // Flag clears on the edge that advances the tail
    always_ff @(posedge clk) begin
        if (rst) begin
            id_done_r <= '0;
        end else begin
            id_done_r <= (id_done_r & ~id_retire) | id_done_new;
        end
    end

    // Registered retire port
    always_ff @(posedge clk) begin
        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= retired;
        end
        retire.id      <= oldest_id;
        retire.rd_addr <= packet_table[oldest_id];
        retire.rd_data <= result_table[oldest_id];
    end

endmodule

//--- testbench/tb_wb_subsystem.sv
// Testbench for the write-back subsystem with MAX_INFLIGHT of 8
// Expected results come from a reference function, checked in retire order
`timescale 1ns/10ps

module tb_wb_subsystem;
    import wb_pkg::*;

    localparam int MAX_INFLIGHT = 8;
    localparam int TIMEOUT      = 200;
    localparam int NUM_RANDOM   = 400;

    // One expected retirement
    typedef struct packed {
        id_t             id;
        reg_addr_t       rd_addr;
        logic [XLEN-1:0] data;
    } expect_t;

    logic            clk;
    logic            rst;
    logic            issue_valid;
    issue_packet_t   issue;
    reg_addr_t       read_addr;
    logic            issue_ready;
    retire_t         retire;
    logic [31:0]     read_data;

    expect_t         pending [$];
    logic [XLEN-1:0] shadow [32];
    int              errors;
    int              issued_count;
    int              retired_count;

    wb_subsystem #(
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .read_addr   (read_addr),
        .issue_ready (issue_ready),
        .retire      (retire),
        .read_data   (read_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ///////////////////////////////
    // Reference model
    ///////////////////////////////
    function automatic logic [XLEN-1:0] ref_result(opcode_t op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            default: return prod[XLEN-1:0];
        endcase
    endfunction

    ///////////////////////////////
    // Checker
    ///////////////////////////////
    // Pop first, since a retirement at this edge belongs to an older issue
    always @(posedge clk) begin : retire_monitor
        expect_t head;
        expect_t entry;
        if (!rst) begin
            if (retire.valid) begin
                assert (pending.size() != 0) else begin
                    errors++;
                    $display("Error at %0t: retirement seen with no instruction pending",
                             $time);
                end
                if (pending.size() != 0) begin
                    head = pending.pop_front();
                    retired_count++;
                    assert (retire.id == head.id) else begin
                        errors++;
                        $display("Error at %0t: retire id %0d, expected %0d",
                                 $time, retire.id, head.id);
                    end
                    assert (retire.rd_addr == head.rd_addr) else begin
                        errors++;
                        $display("Error at %0t: retire rd_addr %0d, expected %0d",
                                 $time, retire.rd_addr, head.rd_addr);
                    end
                    assert (retire.rd_data == head.data) else begin
                        errors++;
                        $display("Error at %0t: retire rd_data %h, expected %h",
                                 $time, retire.rd_data, head.data);
                    end
                end
            end
            // Ready falls only with a full window
            assert (issue_ready == ((issued_count - retired_count) < MAX_INFLIGHT)) else begin
                errors++;
                $display("Error at %0t: issue_ready %b with %0d in flight",
                         $time, issue_ready, issued_count - retired_count);
            end
            if (issue_valid && issue_ready) begin
                entry.id      = id_t'(issued_count % MAX_INFLIGHT);
                entry.rd_addr = issue.rd_addr;
                entry.data    = ref_result(issue.op, issue.a, issue.b);
                pending.push_back(entry);
                if (issue.rd_addr != '0) begin
                    shadow[issue.rd_addr] = entry.data;
                end
                issued_count++;
            end
        end
    end

    ///////////////////////////////
    // Run control
    ///////////////////////////////
    task automatic finish_run();
        $display("Errors: %0d, issued %0d, retired %0d", errors, issued_count, retired_count);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic stall_abort(string msg);
        errors++;
        $display("Timeout at %0t: %s", $time, msg);
        finish_run();
    endtask

    // Called at a rising edge and returns on the accepting edge
    task automatic send(opcode_t op, reg_addr_t rd, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        issue_packet_t pkt;
        int            waited;
        pkt.op      = op;
        pkt.rd_addr = rd;
        pkt.a       = a;
        pkt.b       = b;
        waited      = 0;
        issue_valid <= 1'b1;
        issue       <= pkt;
        @(posedge clk);
        while (!issue_ready && waited < TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (waited >= TIMEOUT) begin
            stall_abort("issue_ready stayed low and no instruction was accepted");
        end else begin
            issue_valid <= 1'b0;
        end
    endtask

    // Queue size sampled on the falling edge
    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (pending.size() != 0) begin
            stall_abort($sformatf("retirement stalled with %0d pending", pending.size()));
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            read_addr <= reg_addr_t'(r);
            @(negedge clk);
            assert (read_data == shadow[r]) else begin
                errors++;
                $display("Error at %0t: register %0d reads %h, expected %h",
                         $time, r, read_data, shadow[r]);
            end
        end
    endtask

    ///////////////////////////////
    // Stimulus
    ///////////////////////////////
    initial begin
        void'($urandom(32'hc90d_58ca));
        rst           = 1'b1;
        issue_valid   = 1'b0;
        issue         = '0;
        read_addr     = '0;
        errors        = 0;
        issued_count  = 0;
        retired_count = 0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!retire.valid && issue_ready) else begin
            errors++;
            $display("Error at %0t: idle state wrong after reset", $time);
        end

        // Short ALU ops right behind a multiply must wait for it
        @(posedge clk);
        send(op_mul, 5'd3, 32'h1234_5678, 32'h9abc_def0);
        send(op_add, 5'd4, 32'hffff_ffff, 32'h0000_0002);
        send(op_sub, 5'd0, 32'h0000_0001, 32'h0000_0005);
        send(op_xor, 5'd5, 32'ha5a5_a5a5, 32'h0f0f_0f0f);
        drain();

        // Back-to-back multiplies
        // Retirement keeps pace, so the window never fills
        @(posedge clk);
        repeat (MAX_INFLIGHT) begin
            send(op_mul, reg_addr_t'($urandom_range(31, 0)), $urandom, $urandom);
        end
        drain();

        // Random mix with gaps in issue_valid
        @(posedge clk);
        repeat (NUM_RANDOM) begin
            send(opcode_t'($urandom_range(3, 0)), reg_addr_t'($urandom_range(31, 0)),
                 $urandom, $urandom);
            if ($urandom_range(3, 0) == 0) begin
                repeat ($urandom_range(3, 1)) @(posedge clk);
            end
        end
        drain();
        check_regs();

        finish_run();
    end

endmodule
